// File: sim.f
common/periph_pkg.sv
hdl/prescaler.sv
spi/spi.sv
timer/timer.sv
hdl/periph_bus.sv
hdl/periph_top.sv
verif/periph_properties.sv
verif/periph_tb.sv

// File: Makefile
TOP := periph_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f sim.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Verification passed$$"

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: verif/periph_tb.sv
`timescale 1ns/1ps

module periph_tb;

	import periph_pkg::*;

	localparam int NUM_XFERS = 40;
	localparam int NUM_TMR_RUNS = 4;
	// Slowest transfer is 16 half periods at div 7, timer runs take up to 32 ticks at div 3
	localparam int TIMEOUT_CYCLES = NUM_XFERS * 16 * 128 + NUM_TMR_RUNS * 2 * 32 * 8 + 5000;

	logic clk;
	logic n_reset;
	logic periph_sel;
	logic bus_we;
	logic bus_oe;
	addr_t periph_addr;
	data_t bus_wdata;
	data_t bus_rdata;
	logic irq, miso, cs, mosi, sck;

	int cycle_count = 0;
	logic irq_at_read;	// irq seen in the same sample as the read data

	// SPI slave model
	logic slave_armed, slave_cpol, slave_cpha, sck_last;
	data_t slave_tx, slave_rx;
	int slave_out_idx, slave_samples;

	periph_top u_dut (
		.clk(clk),
		.n_reset(n_reset),
		.periph_sel(periph_sel),
		.bus_we(bus_we),
		.bus_oe(bus_oe),
		.periph_addr(periph_addr),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata),
		.irq(irq),
		.miso(miso),
		.cs(cs),
		.mosi(mosi),
		.sck(sck)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run("The run hung and reached the cycle limit");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input data_t got, input data_t expected);
		if (got !== expected)
			abort_run($sformatf("CHECK FAILED at %0t: %s got 0x%02h expected 0x%02h",
				$time, name, got, expected));
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected)
			abort_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, name, got, expected));
	endtask

	function automatic data_t ctrl_word(input logic en, input logic ie, input logic cpha,
		input logic cpol, input div_sel_t div);
		data_t w;
		w = '0;
		w[CTRL_EN] = en;
		w[CTRL_IE] = ie;
		w[CTRL_CPHA] = cpha;
		w[CTRL_CPOL] = cpol;
		w[CTRL_DIV_MSB : CTRL_DIV_LSB] = div;
		return w;
	endfunction

	function automatic data_t stat_word(input logic txe, input logic rxne, input logic tif);
		data_t w;
		w = '0;
		w[STAT_TXE] = txe;
		w[STAT_RXNE] = rxne;
		w[STAT_TIF] = tif;
		return w;
	endfunction

	function automatic addr_t spi_reg(input logic [1:0] r);
		return {2'b00, r};
	endfunction

	function automatic addr_t tmr_reg(input logic [1:0] r);
		return {2'b10, r};
	endfunction

	// Timer model
	function automatic int tick_period(input div_sel_t div);
		return 1 << div;
	endfunction

	function automatic int expiry_interval(input data_t reload, input div_sel_t div);
		return (int'(reload) + 1) * tick_period(div);
	endfunction

	task automatic bus_write(input addr_t a, input data_t d);
		@(posedge clk);
		#1;
		periph_sel = 1'b1;
		bus_we = 1'b1;
		periph_addr = a;
		bus_wdata = d;
		@(posedge clk);
		#1;
		periph_sel = 1'b0;
		bus_we = 1'b0;
	endtask

	task automatic bus_read(input addr_t a, output data_t d);
		@(posedge clk);
		#1;
		periph_sel = 1'b1;
		bus_oe = 1'b1;
		periph_addr = a;
		@(negedge clk);
		d = bus_rdata;
		irq_at_read = irq;
		@(posedge clk);
		#1;
		periph_sel = 1'b0;
		bus_oe = 1'b0;
	endtask

	task automatic arm_slave(input data_t tx, input logic cpol, input logic cpha);
		slave_tx = tx;
		slave_rx = '0;
		slave_cpol = cpol;
		slave_cpha = cpha;
		slave_samples = 0;
		slave_out_idx = cpha ? 0 : 1;
		miso = cpha ? 1'b0 : tx[7];	// cpha 0 needs the MSB before the first edge
		sck_last = sck;
		slave_armed = 1'b1;
	endtask

	// Pins are looked at 1 ns after each rising clk edge, once they have settled
	initial begin
		sck_last = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (slave_armed && cs && sck !== sck_last) begin
				if ((sck != slave_cpol) ^ slave_cpha) begin
					slave_rx = {slave_rx[6:0], mosi};	// Sample edge
					slave_samples++;
				end else if (slave_out_idx < 8) begin
					miso = slave_tx[7 - slave_out_idx];
					slave_out_idx++;
				end
			end
			sck_last = sck;
		end
	end

	task automatic check_reset_state();
		data_t rd;
		check_bit("sck", sck, 1'b0);
		check_bit("cs", cs, 1'b0);
		check_bit("mosi", mosi, 1'b0);
		check_bit("irq", irq, 1'b0);
		check_data("bus_rdata_idle", bus_rdata, '0);
		bus_read(spi_reg(REG_STAT), rd);
		check_data("spi_stat_reset", rd, stat_word(1'b1, 1'b0, 1'b0));
		bus_read(spi_reg(REG_CTRL), rd);
		check_data("spi_ctrl_reset", rd, '0);
		bus_read(tmr_reg(REG_STAT), rd);
		check_data("tmr_stat_reset", rd, '0);
	endtask

	task automatic check_decode();
		data_t rd;
		bus_read(4'd3, rd);
		check_data("spi_unused_3", rd, '0);
		bus_read(4'd6, rd);
		check_data("spi_unused_6", rd, '0);
		bus_read(4'd13, rd);
		check_data("tmr_unused_13", rd, '0);
		bus_write(spi_reg(REG_CTRL), 8'hFF);
		bus_read(spi_reg(REG_CTRL), rd);
		check_data("spi_ctrl_mask", rd, ctrl_word(1'b1, 1'b1, 1'b1, 1'b1, 3'd7));
		bus_write(spi_reg(REG_CTRL), '0);
		bus_write(tmr_reg(REG_CTRL), 8'hFF);
		bus_read(tmr_reg(REG_CTRL), rd);
		check_data("tmr_ctrl_mask", rd, ctrl_word(1'b1, 1'b1, 1'b0, 1'b0, 3'd7));
		bus_write(tmr_reg(REG_CTRL), '0);
		bus_write(tmr_reg(REG_STAT), stat_word(1'b0, 1'b0, 1'b1));
		// Interleaved accesses, each block must keep its own values
		bus_write(spi_reg(REG_CTRL), ctrl_word(1'b0, 1'b1, 1'b1, 1'b0, 3'd5));
		bus_write(tmr_reg(REG_DATA), 8'h5A);
		bus_read(spi_reg(REG_DATA), rd);
		bus_read(tmr_reg(REG_COUNT), rd);
		check_data("tmr_count_kept", rd, 8'h5A);
		bus_read(spi_reg(REG_CTRL), rd);
		check_data("spi_ctrl_kept", rd, ctrl_word(1'b0, 1'b1, 1'b1, 1'b0, 3'd5));
		bus_read(tmr_reg(REG_DATA), rd);
		check_data("tmr_reload_kept", rd, 8'h5A);
		bus_read(spi_reg(REG_STAT), rd);
		check_data("spi_stat_kept", rd, stat_word(1'b1, 1'b0, 1'b0));
		bus_write(spi_reg(REG_CTRL), '0);
	endtask

	task automatic run_transfer();
		logic cpol, cpha, ie, busy_write;
		div_sel_t div;
		data_t tx, slave_byte, rd, st;
		cpol = 1'($urandom);
		cpha = 1'($urandom);
		ie = 1'($urandom);
		busy_write = ($urandom % 4) == 0;
		div = div_sel_t'($urandom % 4);
		tx = data_t'($urandom);
		slave_byte = data_t'($urandom);
		bus_write(spi_reg(REG_CTRL), ctrl_word(1'b1, ie, cpha, cpol, div));
		arm_slave(slave_byte, cpol, cpha);
		bus_write(spi_reg(REG_DATA), tx);
		if (busy_write)
			bus_write(spi_reg(REG_DATA), ~tx);	// Lands while the shift runs
		do begin
			bus_read(spi_reg(REG_STAT), st);
			if (!st[STAT_RXNE]) begin
				check_bit("txe_busy", st[STAT_TXE], 1'b0);
				check_bit("irq_busy", irq_at_read, 1'b0);
			end
		end while (!st[STAT_RXNE]);
		slave_armed = 1'b0;
		check_data("spi_stat_done", st, stat_word(1'b1, 1'b1, 1'b0));
		check_bit("irq_done", irq_at_read, ie);
		check_data("slave_rx", slave_rx, tx);
		check_data("slave_samples", data_t'(slave_samples), 8'd8);
		bus_read(spi_reg(REG_DATA), rd);
		check_data("spi_rx_data", rd, slave_byte);
		bus_read(spi_reg(REG_STAT), st);
		check_data("spi_stat_read", st, stat_word(1'b1, 1'b0, 1'b0));
		check_bit("irq_after_read", irq_at_read, 1'b0);
	endtask

	task automatic run_timer();
		div_sel_t div;
		data_t reload, st, cnt_a, cnt_b;
		int period, expected, cycles;
		div = div_sel_t'($urandom % 4);
		reload = data_t'(4 + $urandom % 28);
		period = tick_period(div);
		expected = expiry_interval(reload, div);
		bus_write(tmr_reg(REG_CTRL), '0);
		bus_write(tmr_reg(REG_DATA), reload);
		bus_write(tmr_reg(REG_STAT), stat_word(1'b0, 1'b0, 1'b1));
		bus_write(tmr_reg(REG_CTRL), ctrl_word(1'b1, 1'b1, 1'b0, 1'b0, div));
		cycles = 0;
		while (irq !== 1'b1) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (cycles > expected + period || cycles < expected - period)
			abort_run($sformatf("Timer expired after %0d cycles, the model predicts %0d +/- %0d",
				cycles, expected, period));
		bus_read(tmr_reg(REG_STAT), st);
		check_data("tmr_stat_tif", st, stat_word(1'b0, 1'b0, 1'b1));
		bus_write(tmr_reg(REG_CTRL), ctrl_word(1'b0, 1'b1, 1'b0, 1'b0, div));
		bus_read(tmr_reg(REG_COUNT), cnt_a);
		repeat (2 * period + 3) @(posedge clk);
		bus_read(tmr_reg(REG_COUNT), cnt_b);
		check_data("tmr_count_held", cnt_b, cnt_a);
		bus_write(tmr_reg(REG_STAT), stat_word(1'b0, 1'b0, 1'b1));
		bus_read(tmr_reg(REG_STAT), st);
		check_data("tmr_stat_clear", st, '0);
		check_bit("irq_tif_clear", irq_at_read, 1'b0);
	endtask

	initial begin
		void'($urandom(45));
		n_reset = 1'b0;
		periph_sel = 1'b0;
		bus_we = 1'b0;
		bus_oe = 1'b0;
		periph_addr = '0;
		bus_wdata = '0;
		miso = 1'b0;
		irq_at_read = 1'b0;
		slave_armed = 1'b0;
		slave_cpol = 1'b0;
		slave_cpha = 1'b0;
		slave_tx = '0;
		slave_rx = '0;
		slave_out_idx = 0;
		slave_samples = 0;
		repeat (3) @(posedge clk);
		#1;
		n_reset = 1'b1;
		check_reset_state();
		check_decode();
		repeat (NUM_XFERS) run_transfer();
		repeat (NUM_TMR_RUNS) run_timer();
		$display("Verification passed");
		$finish;
	end

endmodule

// File: verif/periph_properties.sv
`timescale 1ns/1ps

module spi_properties (
	input logic clk,
	input logic n_reset,
	input periph_pkg::spi_state_t state,
	input logic tick,
	input logic en,
	input logic cpol,
	input logic sck,
	input logic txe,
	input logic rxne
);

	import periph_pkg::*;

	logic [4:0] tick_cnt;	// Ticks seen in the current shift phase

	always_ff @(posedge clk, negedge n_reset)
		if (~n_reset)
			tick_cnt <= '0;
		else if (state != SPI_SHIFT)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= tick_cnt + 5'd1;

	idle_sck: assert property (@(posedge clk) disable iff (!n_reset)
		state == SPI_IDLE |-> sck == cpol)
		else $error("sck differs from cpol while the sequencer is idle");

	// Disabled block keeps TXE set and RXNE clear
	flags_disabled: assert property (@(posedge clk) disable iff (!n_reset)
		!en |-> (txe && !rxne))
		else $error("TXE or RXNE moved while the SPI is disabled");

	xfer_length: assert property (@(posedge clk) disable iff (!n_reset)
		state == SPI_SHIFT |-> tick_cnt < 5'd16)
		else $error("SPI transfer ran past 16 ticks");

endmodule

bind spi spi_properties u_spi_props (
	.clk(clk),
	.n_reset(n_reset),
	.state(state),
	.tick(tick),
	.en(en),
	.cpol(cpol),
	.sck(sck),
	.txe(txe),
	.rxne(rxne)
);

// File: hdl/periph_top.sv
`timescale 1ns/1ps

module periph_top (
	input logic clk,
	input logic n_reset,
	input logic periph_sel,
	input logic bus_we,
	input logic bus_oe,
	input periph_pkg::addr_t periph_addr,
	input periph_pkg::data_t bus_wdata,
	output periph_pkg::data_t bus_rdata,
	output logic irq,
	input logic miso,
	output logic cs,
	output logic mosi,
	output logic sck
);

	import periph_pkg::*;

	logic spi_sel, tmr_sel;
	logic spi_irq, tmr_irq;
	data_t spi_rdata;
	data_t tmr_rdata;

	periph_bus u_bus (
		.periph_sel(periph_sel),
		.bus_we(bus_we),
		.bus_oe(bus_oe),
		.periph_addr(periph_addr),
		.bus_rdata(bus_rdata),
		.spi_sel(spi_sel),
		.tmr_sel(tmr_sel),
		.spi_rdata(spi_rdata),
		.tmr_rdata(tmr_rdata),
		.spi_irq(spi_irq),
		.tmr_irq(tmr_irq),
		.irq(irq)
	);

	// Both blocks see the same address, strobes and write data
	spi u_spi (
		.clk(clk),
		.n_reset(n_reset),
		.sel(spi_sel),
		.we(bus_we),
		.oe(bus_oe),
		.addr(periph_addr),
		.wdata(bus_wdata),
		.rdata(spi_rdata),
		.irq(spi_irq),
		.miso(miso),
		.cs(cs),
		.mosi(mosi),
		.sck(sck)
	);

	timer u_timer (
		.clk(clk),
		.n_reset(n_reset),
		.sel(tmr_sel),
		.we(bus_we),
		.oe(bus_oe),
		.addr(periph_addr),
		.wdata(bus_wdata),
		.rdata(tmr_rdata),
		.irq(tmr_irq)
	);

endmodule

// File: hdl/periph_bus.sv
`timescale 1ns/1ps

module periph_bus (
	input logic periph_sel,
	input logic bus_we,
	input logic bus_oe,
	input periph_pkg::addr_t periph_addr,
	output periph_pkg::data_t bus_rdata,
	output logic spi_sel,
	output logic tmr_sel,
	input periph_pkg::data_t spi_rdata,
	input periph_pkg::data_t tmr_rdata,
	input logic spi_irq,
	input logic tmr_irq,
	output logic irq
);

	import periph_pkg::*;

	logic access;
	logic tmr_block;

	// Selects only for a real read or write cycle
	assign access = periph_sel & (bus_we | bus_oe);
	assign tmr_block = periph_addr[ADDR_BLOCK_BIT];

	assign spi_sel = access & ~tmr_block;
	assign tmr_sel = access & tmr_block;

	always_comb begin
		bus_rdata = '0;	// Idle bus reads zero
		if (bus_oe) begin
			if (spi_sel)
				bus_rdata = spi_rdata;
			else if (tmr_sel)
				bus_rdata = tmr_rdata;
		end
	end

	assign irq = spi_irq | tmr_irq;

endmodule

// File: timer/timer.sv
`timescale 1ns/1ps

module timer (
	input logic clk,
	input logic n_reset,
	input logic sel,
	input logic we,
	input logic oe,
	input periph_pkg::addr_t addr,
	input periph_pkg::data_t wdata,
	output periph_pkg::data_t rdata,
	output logic irq
);

	import periph_pkg::*;

	data_t ctrl;
	data_t reload;
	data_t count;
	data_t stat;
	logic tif;
	div_sel_t div;

	logic wr, rd, reg_hit;
	logic ctrl_wr, stat_wr, data_wr;
	logic en, tick, expire;

	assign wr = sel & we;
	assign rd = sel & oe;
	assign reg_hit = ~addr[2];
	assign ctrl_wr = wr & reg_hit & (addr[1:0] == REG_CTRL);
	assign stat_wr = wr & reg_hit & (addr[1:0] == REG_STAT);
	assign data_wr = wr & reg_hit & (addr[1:0] == REG_DATA);

	assign en = ctrl[CTRL_EN];
	assign div = ctrl[CTRL_DIV_MSB : CTRL_DIV_LSB];

	prescaler u_prescaler (
		.clk(clk),
		.n_reset(n_reset),
		.div(div),
		.tick(tick)
	);

	// A tick at zero reloads, so one period is reload + 1 ticks
	assign expire = en & tick & (count == '0);

	always_ff @(posedge clk, negedge n_reset)
		if (~n_reset)
			ctrl <= '0;
		else if (ctrl_wr)
			ctrl <= wdata;

	always_ff @(posedge clk, negedge n_reset)
		if (~n_reset)
			reload <= '0;
		else if (data_wr)
			reload <= wdata;

	always_ff @(posedge clk, negedge n_reset)
		if (~n_reset)
			count <= '0;
		else if (data_wr)
			count <= wdata;	// New reload value starts a fresh period
		else if (expire)
			count <= reload;
		else if (en && tick)
			count <= count - 1'b1;

	// Expiry wins over a clear in the same cycle
	always_ff @(posedge clk, negedge n_reset)
		if (~n_reset)
			tif <= 1'b0;
		else if (expire)
			tif <= 1'b1;
		else if (stat_wr && wdata[STAT_TIF])
			tif <= 1'b0;

	always_comb begin
		stat = '0;
		stat[STAT_TIF] = tif;
		rdata = '0;
		if (rd && reg_hit) begin
			case (addr[1:0])
				REG_CTRL:  rdata = ctrl & TMR_CTRL_MASK;
				REG_STAT:  rdata = stat;
				REG_DATA:  rdata = reload;
				REG_COUNT: rdata = count;
				default:   rdata = '0;
			endcase
		end
	end

	assign irq = ctrl[CTRL_IE] & tif;

endmodule

// File: spi/spi.sv
`timescale 1ns/1ps

module spi (
	input logic clk,
	input logic n_reset,
	input logic sel,
	input logic we,
	input logic oe,
	input periph_pkg::addr_t addr,
	input periph_pkg::data_t wdata,
	output periph_pkg::data_t rdata,
	output logic irq,
	input logic miso,
	output logic cs,
	output logic mosi,
	output logic sck
);

	import periph_pkg::*;

	data_t ctrl;
	data_t tx_data;
	data_t rx_data;
	data_t rx_next;
	data_t shreg;
	data_t stat;
	logic txe;
	logic rxne;
	logic miso_bit;
	logic [3:0] half_cnt;	// SCK edges done in this transfer
	spi_state_t state;
	div_sel_t div;

	logic wr, rd, reg_hit;
	logic ctrl_wr, data_wr, data_rd;
	logic en, en_next, cpol, cpha;
	logic start, tick, leading, last_half;
	logic sample_now, shift_now;

	assign wr = sel & we;
	assign rd = sel & oe;
	assign reg_hit = ~addr[2];	// Offsets 4 to 7 are unused
	assign ctrl_wr = wr & reg_hit & (addr[1:0] == REG_CTRL);
	assign data_wr = wr & reg_hit & (addr[1:0] == REG_DATA);
	assign data_rd = rd & reg_hit & (addr[1:0] == REG_DATA);

	assign en = ctrl[CTRL_EN];
	assign en_next = ctrl_wr ? wdata[CTRL_EN] : en;	// Disable acts at the write edge
	assign cpol = ctrl[CTRL_CPOL];
	assign cpha = ctrl[CTRL_CPHA];
	assign div = ctrl[CTRL_DIV_MSB : CTRL_DIV_LSB];

	// Writes while busy or disabled are dropped
	assign start = data_wr & en & (state == SPI_IDLE);

	prescaler u_prescaler (
		.clk(clk),
		.n_reset(n_reset),
		.div(div),
		.tick(tick)
	);

	// Even edge count means the next edge leaves the idle level
	assign leading = ~half_cnt[0];
	assign last_half = half_cnt == 4'd15;

	// cpha 0 samples on leading edges and shifts on trailing ones
	// cpha 1 shifts on leading edges after the first and samples on trailing ones
	assign sample_now = (state == SPI_SHIFT) & tick & (leading ^ cpha);
	assign shift_now = cpha ? (leading & (half_cnt != 4'd0)) : ~leading;

	// With cpha 1 the last sampled bit is still outside the shift register
	assign rx_next = cpha ? {shreg[6:0], miso_bit} : shreg;

	always_ff @(posedge clk, negedge n_reset)
		if (~n_reset)
			ctrl <= '0;
		else if (ctrl_wr)
			ctrl <= wdata;

	always_ff @(posedge clk)
		if (start)
			tx_data <= wdata;

	always_ff @(posedge clk)
		if (sample_now)
			miso_bit <= miso;

	always_ff @(posedge clk, negedge n_reset)
		if (~n_reset) begin
			state <= SPI_IDLE;
			half_cnt <= '0;
			shreg <= '0;
		end else if (~en_next) begin
			state <= SPI_IDLE;
			half_cnt <= '0;
		end else begin
			case (state)
				SPI_IDLE:
					if (start)
						state <= SPI_LOAD;
				SPI_LOAD: begin
					shreg <= tx_data;	// MSB on mosi before the first edge
					half_cnt <= '0;
					state <= SPI_SHIFT;
				end
				SPI_SHIFT:
					if (tick) begin
						half_cnt <= half_cnt + 4'd1;	// Wraps to 0 after 16 edges
						if (shift_now)
							shreg <= {shreg[6:0], miso_bit};
						if (last_half)
							state <= SPI_DONE;
					end
				SPI_DONE:
					state <= SPI_IDLE;
				default:
					state <= SPI_IDLE;
			endcase
		end

	always_ff @(posedge clk, negedge n_reset)
		if (~n_reset)
			rx_data <= '0;
		else if (state == SPI_DONE)
			rx_data <= rx_next;	// Overwrites an unread byte

	always_ff @(posedge clk, negedge n_reset)
		if (~n_reset) begin
			txe <= 1'b1;
			rxne <= 1'b0;
		end else if (~en_next) begin
			txe <= 1'b1;
			rxne <= 1'b0;
		end else if (state == SPI_DONE) begin
			txe <= 1'b1;	// Both flags rise in the same cycle
			rxne <= 1'b1;
		end else begin
			if (start)
				txe <= 1'b0;
			if (data_rd)
				rxne <= 1'b0;
		end

	always_comb begin
		stat = '0;
		stat[STAT_TXE] = txe;
		stat[STAT_RXNE] = rxne;
		rdata = '0;
		if (rd && reg_hit) begin
			case (addr[1:0])
				REG_CTRL: rdata = ctrl & SPI_CTRL_MASK;
				REG_STAT: rdata = stat & SPI_STAT_MASK;
				REG_DATA: rdata = rx_data;
				default:  rdata = '0;
			endcase
		end
	end

	assign irq = ctrl[CTRL_IE] & rxne;
	assign cs = en;
	assign mosi = shreg[7];
	assign sck = cpol ^ half_cnt[0];	// Back at cpol once the transfer ends

endmodule

// File: hdl/prescaler.sv
`timescale 1ns/1ps

module prescaler (
	input logic clk,
	input logic n_reset,
	input periph_pkg::div_sel_t div,
	output logic tick
);

	import periph_pkg::*;

	logic [DIV_N - 1 : 0] cnt;
	logic [DIV_N - 1 : 0] mask;

	// Low div bits of the counter, all ones just before they wrap
	assign mask = ({{(DIV_N - 1){1'b0}}, 1'b1} << div) - 1'b1;
	assign tick = (cnt & mask) == mask;	// div 0 gives a tick every cycle

	always_ff @(posedge clk, negedge n_reset)
		if (~n_reset)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;

endmodule

// File: common/periph_pkg.sv
package periph_pkg;

	// Bus and register word
	typedef logic [7:0] data_t;

	// Bit 3 picks the block, bits 1:0 the register inside it
	typedef logic [3:0] addr_t;

	typedef logic [2:0] div_sel_t;	// Prescaler rate, tick every 2^div cycles

	localparam int ADDR_BLOCK_BIT = 3;	// 0 spi, 1 timer

	// Register offsets within a block
	localparam logic [1:0] REG_CTRL  = 2'd0;
	localparam logic [1:0] REG_STAT  = 2'd1;
	localparam logic [1:0] REG_DATA  = 2'd2;	// Timer reload value
	localparam logic [1:0] REG_COUNT = 2'd3;	// Timer only, read only

	// Control register bits
	localparam int CTRL_DIV_LSB = 0;
	localparam int CTRL_DIV_MSB = 2;
	localparam int CTRL_CPOL    = 3;
	localparam int CTRL_CPHA    = 4;
	localparam int CTRL_IE      = 5;
	localparam int CTRL_EN      = 7;

	// Status register bits
	localparam int STAT_TXE  = 0;
	localparam int STAT_RXNE = 1;
	localparam int STAT_TIF  = 2;

	// Bits that read back, the rest read as zero
	localparam data_t SPI_CTRL_MASK = 8'b1011_1111;	// EN, IE, CPHA, CPOL, DIV
	localparam data_t SPI_STAT_MASK = 8'b0000_0011;	// RXNE, TXE
	localparam data_t TMR_CTRL_MASK = 8'b1010_0111;	// EN, IE, DIV

	// Prescaler counter stages
	localparam int DIV_N = 8;

	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_LOAD,
		SPI_SHIFT,
		SPI_DONE
	} spi_state_t;

endpackage
